//--- nanorv32_pkg.sv
/*
 * NanoRV32 shared definitions
 * ALU operation codes, RV32I opcode and funct fields, instruction word views
 */
`default_nettype none

package nanorv32_pkg;

   // ALU operation select codes
   localparam logic [3:0] alu_op_nop         = 4'd0;  // Pass operand b
   localparam logic [3:0] alu_op_or          = 4'd1;
   localparam logic [3:0] alu_op_and         = 4'd2;
   localparam logic [3:0] alu_op_xor         = 4'd3;
   localparam logic [3:0] alu_op_sub         = 4'd4;
   localparam logic [3:0] alu_op_add         = 4'd5;
   localparam logic [3:0] alu_op_lshift      = 4'd6;
   localparam logic [3:0] alu_op_rshift      = 4'd7;
   localparam logic [3:0] alu_op_arshift     = 4'd8;
   localparam logic [3:0] alu_op_lt_signed   = 4'd9;
   localparam logic [3:0] alu_op_lt_unsigned = 4'd10;
   localparam logic [3:0] alu_op_ge_signed   = 4'd11;
   localparam logic [3:0] alu_op_ge_unsigned = 4'd12;
   localparam logic [3:0] alu_op_eq          = 4'd13;
   localparam logic [3:0] alu_op_neq         = 4'd14;

   // Major opcodes handled by the execute unit
   localparam logic [6:0] opc_op     = 7'b0110011;
   localparam logic [6:0] opc_op_imm = 7'b0010011;
   localparam logic [6:0] opc_lui    = 7'b0110111;
   localparam logic [6:0] opc_branch = 7'b1100011;

   // funct3 for OP and OP-IMM
   localparam logic [2:0] f3_add_sub = 3'b000;
   localparam logic [2:0] f3_sll     = 3'b001;
   localparam logic [2:0] f3_slt     = 3'b010;
   localparam logic [2:0] f3_sltu    = 3'b011;
   localparam logic [2:0] f3_xor     = 3'b100;
   localparam logic [2:0] f3_srl_sra = 3'b101;
   localparam logic [2:0] f3_or      = 3'b110;
   localparam logic [2:0] f3_and     = 3'b111;

   // funct3 for BRANCH, 010 and 011 are reserved
   localparam logic [2:0] f3_beq  = 3'b000;
   localparam logic [2:0] f3_bne  = 3'b001;
   localparam logic [2:0] f3_blt  = 3'b100;
   localparam logic [2:0] f3_bge  = 3'b101;
   localparam logic [2:0] f3_bltu = 3'b110;
   localparam logic [2:0] f3_bgeu = 3'b111;

   // funct7 values, alt selects sub and sra
   localparam logic [6:0] f7_base = 7'b0000000;
   localparam logic [6:0] f7_alt  = 7'b0100000;

   // R-type layout
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } instr_r_t;

   // I-type layout
   typedef struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } instr_i_t;

   // One instruction word, seen either way
   typedef union packed {
      instr_r_t    r;
      instr_i_t    i;
      logic [31:0] raw;
   } instr_u;

endpackage

`default_nettype wire

//--- nanorv32_alu.sv
/*
 * NanoRV32 ALU
 * Combinational logic, arithmetic, shift and compare on two 32-bit operands,
 * plus a nonzero flag used as the branch condition
 */
`timescale 1ns/1ps
`default_nettype none

module nanorv32_alu (
   input  wire logic [31:0] porta,
   input  wire logic [31:0] portb,
   input  wire logic [3:0]  op_sel,
   output logic      [31:0] alu_res,
   output logic             alu_cond
);

   // Operand a is rs1, operand b is rs2 or the immediate
   always_comb begin
      case (op_sel)
         nanorv32_pkg::alu_op_nop: begin
            alu_res = portb;
         end
         nanorv32_pkg::alu_op_or: begin
            alu_res = porta | portb;
         end
         nanorv32_pkg::alu_op_and: begin
            alu_res = porta & portb;
         end
         nanorv32_pkg::alu_op_xor: begin
            alu_res = porta ^ portb;
         end
         nanorv32_pkg::alu_op_sub: begin
            alu_res = porta - portb;
         end
         nanorv32_pkg::alu_op_add: begin
            alu_res = porta + portb;
         end
         // Shift amount is the low five bits of b
         nanorv32_pkg::alu_op_lshift: begin
            alu_res = porta << portb[4:0];
         end
         nanorv32_pkg::alu_op_rshift: begin
            alu_res = porta >> portb[4:0];
         end
         nanorv32_pkg::alu_op_arshift: begin
            alu_res = $signed(porta) >>> portb[4:0];
         end
         // Compares give 0 or 1
         nanorv32_pkg::alu_op_lt_signed: begin
            alu_res = {31'b0, $signed(porta) < $signed(portb)};
         end
         nanorv32_pkg::alu_op_lt_unsigned: begin
            alu_res = {31'b0, porta < portb};
         end
         nanorv32_pkg::alu_op_ge_signed: begin
            alu_res = {31'b0, $signed(porta) >= $signed(portb)};
         end
         nanorv32_pkg::alu_op_ge_unsigned: begin
            alu_res = {31'b0, porta >= portb};
         end
         nanorv32_pkg::alu_op_eq: begin
            alu_res = {31'b0, porta == portb};
         end
         nanorv32_pkg::alu_op_neq: begin
            alu_res = {31'b0, porta != portb};
         end
         default: begin
            // Spare code 15
            alu_res = 32'b0;
         end
      endcase
   end

   // Branch condition is any bit set
   assign alu_cond = |alu_res;

endmodule

`default_nettype wire

//--- nanorv32_decode.sv
/*
 * NanoRV32 decoder
 * Maps OP, OP-IMM, LUI and BRANCH words to ALU controls, register indices,
 * immediate and write enable; flags anything else as illegal
 */
`timescale 1ns/1ps
`default_nettype none

module nanorv32_decode (
   input  wire nanorv32_pkg::instr_u instr,
   output logic [3:0]                op_sel,
   output logic                      use_imm,
   output logic [31:0]               imm,
   output logic [4:0]                rs1,
   output logic [4:0]                rs2,
   output logic [4:0]                rd,
   output logic                      rd_write,
   output logic                      is_branch,
   output logic                      illegal
);

   logic [6:0] f7;
   logic       f7_ok;

   // R view for register ops, I view for immediates
   assign rs1 = instr.r.rs1;
   assign rs2 = instr.r.rs2;
   assign rd  = instr.r.rd;

   // Upper immediate bits double as funct7 for shift-immediates
   assign f7    = instr.r.funct7;
   assign f7_ok = (f7 == nanorv32_pkg::f7_base) ||
                  ((f7 == nanorv32_pkg::f7_alt) &&
                   ((instr.r.funct3 == nanorv32_pkg::f3_add_sub) ||
                    (instr.r.funct3 == nanorv32_pkg::f3_srl_sra)));

   always_comb begin
      op_sel    = nanorv32_pkg::alu_op_add;
      use_imm   = 1'b0;
      imm       = {{20{instr.i.imm12[11]}}, instr.i.imm12};
      rd_write  = 1'b0;
      is_branch = 1'b0;
      illegal   = 1'b0;
      case (instr.r.opcode)
         nanorv32_pkg::opc_op: begin
            rd_write = 1'b1;
            illegal  = !f7_ok;
            case (instr.r.funct3)
               nanorv32_pkg::f3_add_sub: op_sel = f7[5] ? nanorv32_pkg::alu_op_sub
                                                        : nanorv32_pkg::alu_op_add;
               nanorv32_pkg::f3_sll:     op_sel = nanorv32_pkg::alu_op_lshift;
               nanorv32_pkg::f3_slt:     op_sel = nanorv32_pkg::alu_op_lt_signed;
               nanorv32_pkg::f3_sltu:    op_sel = nanorv32_pkg::alu_op_lt_unsigned;
               nanorv32_pkg::f3_xor:     op_sel = nanorv32_pkg::alu_op_xor;
               nanorv32_pkg::f3_srl_sra: op_sel = f7[5] ? nanorv32_pkg::alu_op_arshift
                                                        : nanorv32_pkg::alu_op_rshift;
               nanorv32_pkg::f3_or:      op_sel = nanorv32_pkg::alu_op_or;
               default:                  op_sel = nanorv32_pkg::alu_op_and;
            endcase
         end
         nanorv32_pkg::opc_op_imm: begin
            rd_write = 1'b1;
            use_imm  = 1'b1;
            case (instr.i.funct3)
               nanorv32_pkg::f3_add_sub: op_sel = nanorv32_pkg::alu_op_add;
               nanorv32_pkg::f3_sll: begin
                  op_sel  = nanorv32_pkg::alu_op_lshift;
                  illegal = (f7 != nanorv32_pkg::f7_base);
               end
               nanorv32_pkg::f3_slt:     op_sel = nanorv32_pkg::alu_op_lt_signed;
               nanorv32_pkg::f3_sltu:    op_sel = nanorv32_pkg::alu_op_lt_unsigned;
               nanorv32_pkg::f3_xor:     op_sel = nanorv32_pkg::alu_op_xor;
               nanorv32_pkg::f3_srl_sra: begin
                  // Bit 30 picks srai
                  op_sel  = instr.i.imm12[10] ? nanorv32_pkg::alu_op_arshift
                                              : nanorv32_pkg::alu_op_rshift;
                  illegal = !f7_ok;
               end
               nanorv32_pkg::f3_or:      op_sel = nanorv32_pkg::alu_op_or;
               default:                  op_sel = nanorv32_pkg::alu_op_and;
            endcase
         end
         nanorv32_pkg::opc_lui: begin
            // Immediate goes straight through the ALU
            rd_write = 1'b1;
            use_imm  = 1'b1;
            op_sel   = nanorv32_pkg::alu_op_nop;
            imm      = {instr.raw[31:12], 12'b0};
         end
         nanorv32_pkg::opc_branch: begin
            is_branch = 1'b1;
            case (instr.r.funct3)
               nanorv32_pkg::f3_beq:  op_sel = nanorv32_pkg::alu_op_eq;
               nanorv32_pkg::f3_bne:  op_sel = nanorv32_pkg::alu_op_neq;
               nanorv32_pkg::f3_blt:  op_sel = nanorv32_pkg::alu_op_lt_signed;
               nanorv32_pkg::f3_bge:  op_sel = nanorv32_pkg::alu_op_ge_signed;
               nanorv32_pkg::f3_bltu: op_sel = nanorv32_pkg::alu_op_lt_unsigned;
               nanorv32_pkg::f3_bgeu: op_sel = nanorv32_pkg::alu_op_ge_unsigned;
               default:               illegal = 1'b1;
            endcase
         end
         default: begin
            illegal = 1'b1;
         end
      endcase
      // No write-back for a rejected word
      if (illegal) begin
         rd_write = 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- nanorv32_regfile.sv
/*
 * NanoRV32 register file
 * 32 x 32-bit, two combinational read ports, one write port, x0 reads zero
 */
`timescale 1ns/1ps
`default_nettype none

module nanorv32_regfile (
   input  wire logic        clk,
   input  wire logic        rst,
   input  wire logic [4:0]  raddr_a,
   input  wire logic [4:0]  raddr_b,
   input  wire logic [4:0]  waddr,
   input  wire logic [31:0] wdata,
   input  wire logic        we,
   output logic      [31:0] rdata_a,
   output logic      [31:0] rdata_b
);

   // x0 has no storage
   logic [31:0] regs [1:31];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int k = 1; k < 32; k++) begin
            regs[k] <= 32'b0;
         end
      end else if (we && (waddr != 5'd0)) begin
         regs[waddr] <= wdata;
      end
   end

   // Address 0 always returns zero
   always_comb begin
      if (raddr_a == 5'd0) begin
         rdata_a = 32'b0;
      end else begin
         rdata_a = regs[raddr_a];
      end
   end

   always_comb begin
      if (raddr_b == 5'd0) begin
         rdata_b = 32'b0;
      end else begin
         rdata_b = regs[raddr_b];
      end
   end

endmodule

`default_nettype wire

//--- nanorv32_exec_ctrl.sv
/*
 * NanoRV32 execute sequencer
 * Four-phase req/ack control, latches the instruction, pulses the
 * register write and holds result, taken and illegal while ack is high
 */
`timescale 1ns/1ps
`default_nettype none

module nanorv32_exec_ctrl (
   input  wire logic                 clk,
   input  wire logic                 rst,
   input  wire logic                 req,
   input  wire nanorv32_pkg::instr_u instr,
   input  wire logic [31:0]          alu_res,
   input  wire logic                 alu_cond,
   input  wire logic                 is_branch,
   input  wire logic                 illegal_dec,
   input  wire logic                 rd_write,
   output nanorv32_pkg::instr_u      instr_q,
   output logic                      we,
   output logic                      ack,
   output logic [31:0]               result,
   output logic                      taken,
   output logic                      illegal
);

   // Sequencer states
   localparam logic [1:0] st_idle = 2'd0;
   localparam logic [1:0] st_exec = 2'd1;
   localparam logic [1:0] st_hold = 2'd2;

   logic [1:0] state;

   // Instruction register, loaded on a new request only
   always_ff @(posedge clk) begin
      if ((state == st_idle) && req) begin
         instr_q <= instr;
      end
   end

   // Write-back happens on the edge that leaves execute
   assign we = (state == st_exec) && rd_write;

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= st_idle;
         ack     <= 1'b0;
         result  <= 32'b0;
         taken   <= 1'b0;
         illegal <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (req) begin
                  state <= st_exec;
               end
            end
            st_exec: begin
               // Capture outputs together with ack
               state   <= st_hold;
               ack     <= 1'b1;
               result  <= illegal_dec ? 32'b0 : alu_res;
               taken   <= alu_cond && is_branch && !illegal_dec;
               illegal <= illegal_dec;
            end
            st_hold: begin
               // Back-pressure, wait for req to drop
               if (!req) begin
                  state <= st_idle;
                  ack   <= 1'b0;
               end
            end
            default: begin
               state <= st_idle;
               ack   <= 1'b0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- nanorv32_exec_top.sv
/*
 * NanoRV32 execute unit
 * Sequencer, decoder, register file and ALU behind a req/ack handshake
 */
`timescale 1ns/1ps
`default_nettype none

module nanorv32_exec_top (
   input  wire logic        clk,
   input  wire logic        rst,
   input  wire logic        req,
   input  wire logic [31:0] instr,
   output logic             ack,
   output logic [31:0]      result,
   output logic             taken,
   output logic             illegal
);

   nanorv32_pkg::instr_u instr_q;
   logic [3:0]  op_sel;
   logic        use_imm;
   logic [31:0] imm;
   logic [4:0]  rs1;
   logic [4:0]  rs2;
   logic [4:0]  rd;
   logic        rd_write;
   logic        is_branch;
   logic        illegal_dec;
   logic        we;
   logic [31:0] rdata_a;
   logic [31:0] rdata_b;
   logic [31:0] portb;
   logic [31:0] alu_res;
   logic        alu_cond;

   nanorv32_exec_ctrl ctrl_i (
      .clk         (clk),
      .rst         (rst),
      .req         (req),
      .instr       (instr),
      .alu_res     (alu_res),
      .alu_cond    (alu_cond),
      .is_branch   (is_branch),
      .illegal_dec (illegal_dec),
      .rd_write    (rd_write),
      .instr_q     (instr_q),
      .we          (we),
      .ack         (ack),
      .result      (result),
      .taken       (taken),
      .illegal     (illegal)
   );

   nanorv32_decode decode_i (
      .instr     (instr_q),
      .op_sel    (op_sel),
      .use_imm   (use_imm),
      .imm       (imm),
      .rs1       (rs1),
      .rs2       (rs2),
      .rd        (rd),
      .rd_write  (rd_write),
      .is_branch (is_branch),
      .illegal   (illegal_dec)
   );

   // ALU result is the write-back data
   nanorv32_regfile regfile_i (
      .clk     (clk),
      .rst     (rst),
      .raddr_a (rs1),
      .raddr_b (rs2),
      .waddr   (rd),
      .wdata   (alu_res),
      .we      (we),
      .rdata_a (rdata_a),
      .rdata_b (rdata_b)
   );

   // Operand b is rs2 or the immediate
   assign portb = use_imm ? imm : rdata_b;

   nanorv32_alu alu_i (
      .porta    (rdata_a),
      .portb    (portb),
      .op_sel   (op_sel),
      .alu_res  (alu_res),
      .alu_cond (alu_cond)
   );

endmodule

`default_nettype wire

//--- tb_clkgen.sv
/*
 * Testbench clock source
 * Free-running clock with a 40 ns period, low at time zero
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
   output logic clk
);

   // Half period of 20 ns
   initial begin
      clk = 1'b0;
      forever begin
         #20 clk = ~clk;
      end
   end

endmodule

`default_nettype wire

//--- nanorv32_exec_tb.sv
/*
 * NanoRV32 execute unit testbench
 * Four-phase driver with random back-pressure, a register file model
 * and assertions on the handshake and on every reported result
 */
`timescale 1ns/1ps
`default_nettype none

module nanorv32_exec_tb;

   localparam int n_rand = 4;
   // Load, immediate, register, branch, x0 and illegal groups
   localparam int txn_total = 62 + (8 + 9 * n_rand) + 20 * n_rand + (48 + 31) + 6 + (5 + 31);
   localparam int timeout_cycles = txn_total * 10 + 16;
   // Branch operand pairs {a, b}, equal, lt, gt, mixed signs, equal negative
   localparam logic [143:0] branch_pairs = {24'h005005, 24'h003009, 24'h009003,
                                            24'hffc007, 24'h007ffc, 24'h800800};

   logic        clk;
   logic        rst;
   logic        req;
   logic [31:0] instr;
   logic        ack;
   logic [31:0] result;
   logic        taken;
   logic        illegal;
   logic [31:0] model_regs [0:31];

   tb_clkgen clkgen_i (.clk(clk));

   nanorv32_exec_top dut_i (
      .clk     (clk),
      .rst     (rst),
      .req     (req),
      .instr   (instr),
      .ack     (ack),
      .result  (result),
      .taken   (taken),
      .illegal (illegal)
   );

   task automatic fail_run(input string msg);
      $display("Error at %0d ns: %s", $time, msg);
      $display("Verification failed");
      $fatal(1, "run stopped at the first error");
   endtask

   // Handshake rules, sampled on every rising edge
   assert property (@(posedge clk) disable iff (rst) $rose(req) |=> !ack ##1 ack)
      else fail_run("ack did not rise exactly two edges after req");
   assert property (@(posedge clk) disable iff (rst)
                    (ack && req) |=> ack && $stable(result) && $stable(taken) && $stable(illegal))
      else fail_run("ack or outputs changed while req was held");
   assert property (@(posedge clk) disable iff (rst) (ack && !req) |=> !ack)
      else fail_run("ack did not fall one edge after req dropped");
   assert property (@(posedge clk) disable iff (rst) (!ack && !req) |=> !ack)
      else fail_run("ack rose without a request");

   // Inputs change 2 ns after the edge, outputs are settled by then
   task automatic step();
      @(posedge clk);
      #2;
   endtask

   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
      nanorv32_pkg::instr_u w;
      w.r.funct7 = f7;
      w.r.rs2    = rs2;
      w.r.rs1    = rs1;
      w.r.funct3 = f3;
      w.r.rd     = rd;
      w.r.opcode = opc;
      return w.raw;
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
      nanorv32_pkg::instr_u w;
      w.i.imm12  = imm;
      w.i.rs1    = rs1;
      w.i.funct3 = f3;
      w.i.rd     = rd;
      w.i.opcode = opc;
      return w.raw;
   endfunction

   function automatic logic [31:0] enc_lui(input logic [19:0] upper, input logic [4:0] rd);
      return {upper, rd, nanorv32_pkg::opc_lui};
   endfunction

   // RV32I semantics for the supported subset, updates the model registers
   task automatic model_exec(input logic [31:0] word, output logic [31:0] res,
                             output logic tk, output logic ill);
      nanorv32_pkg::instr_u w;
      logic [31:0] a;
      logic [31:0] b;
      logic [2:0]  f3;
      logic        is_op;
      logic        alt;
      w.raw = word;
      a     = model_regs[w.r.rs1];
      f3    = w.r.funct3;
      is_op = (w.r.opcode == nanorv32_pkg::opc_op);
      alt   = (w.r.funct7 == 7'h20);
      res   = 32'b0;
      tk    = 1'b0;
      ill   = 1'b0;
      case (w.r.opcode)
         nanorv32_pkg::opc_lui: res = {word[31:12], 12'b0};
         nanorv32_pkg::opc_op, nanorv32_pkg::opc_op_imm: begin
            if (is_op) begin
               b = model_regs[w.r.rs2];
            end else begin
               b = {{20{word[31]}}, word[31:20]};
            end
            // funct7 only matters for OP and for shift immediates
            if (is_op || f3 == 3'b001 || f3 == 3'b101) begin
               ill = !(w.r.funct7 == 7'h00 || (alt && (f3 == 3'b000 || f3 == 3'b101)));
            end
            case (f3)
               3'b000: res = (is_op && alt) ? a - b : a + b;
               3'b001: res = a << b[4:0];
               3'b010: res = {31'b0, $signed(a) < $signed(b)};
               3'b011: res = {31'b0, a < b};
               3'b100: res = a ^ b;
               3'b101: begin
                  if (alt) begin
                     res = $signed(a) >>> b[4:0];
                  end else begin
                     res = a >> b[4:0];
                  end
               end
               3'b110: res = a | b;
               default: res = a & b;
            endcase
         end
         nanorv32_pkg::opc_branch: begin
            b = model_regs[w.r.rs2];
            case (f3)
               3'b000: tk = (a == b);
               3'b001: tk = (a != b);
               3'b100: tk = $signed(a) < $signed(b);
               3'b101: tk = $signed(a) >= $signed(b);
               3'b110: tk = a < b;
               3'b111: tk = a >= b;
               default: ill = 1'b1;
            endcase
            res = {31'b0, tk};
         end
         default: ill = 1'b1;
      endcase
      if (ill) begin
         res = 32'b0;
         tk  = 1'b0;
      end else if (w.r.opcode != nanorv32_pkg::opc_branch && w.r.rd != 5'd0) begin
         model_regs[w.r.rd] = res;
      end
   endtask

   // One four-phase transaction with 0 to 3 cycles of held req
   task automatic run_instr(input logic [31:0] word);
      logic [31:0] exp_res;
      logic        exp_tk;
      logic        exp_ill;
      int          edges;
      int          hold;
      model_exec(word, exp_res, exp_tk, exp_ill);
      req   = 1'b1;
      instr = word;
      edges = 0;
      while (!ack) begin
         step();
         edges++;
      end
      assert (edges == 2)
         else fail_run($sformatf("ack after %0d edges, expected 2", edges));
      assert (result == exp_res)
         else fail_run($sformatf("result 0x%08h, expected 0x%08h for instr 0x%08h",
                                 result, exp_res, word));
      assert (taken == exp_tk)
         else fail_run($sformatf("taken %0b, expected %0b for instr 0x%08h",
                                 taken, exp_tk, word));
      assert (illegal == exp_ill)
         else fail_run($sformatf("illegal %0b, expected %0b for instr 0x%08h",
                                 illegal, exp_ill, word));
      hold = $urandom_range(3, 0);
      repeat (hold) step();
      req = 1'b0;
      step();
      assert (!ack) else fail_run("ack still high one edge after req dropped");
   endtask

   // Reads every register back through add x0, rK, x0
   task automatic check_all_regs();
      for (int k = 1; k < 32; k++) begin
         run_instr(enc_r(7'h00, 5'd0, k[4:0], 3'b000, 5'd0, nanorv32_pkg::opc_op));
      end
   endtask

   // Watchdog sized from the transaction count
   initial begin
      repeat (timeout_cycles) @(posedge clk);
      $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
      $display("Verification failed");
      $fatal(1, "watchdog expired");
   end

   initial begin
      logic [31:0] v;
      logic [4:0]  rd;
      logic [2:0]  f3;
      logic [6:0]  f7;
      logic [11:0] imm;
      logic [23:0] pair;
      void'($urandom(32'h9a42c31d));
      rst   = 1'b1;
      req   = 1'b0;
      instr = 32'b0;
      for (int k = 0; k < 32; k++) begin
         model_regs[k] = 32'b0;
      end
      repeat (16) step();
      rst = 1'b0;
      assert (!ack && !taken && !illegal && result == 32'b0)
         else fail_run("outputs not cleared by reset");

      // Fill x1..x31 through lui and addi
      for (int k = 1; k < 32; k++) begin
         v = $urandom;
         run_instr(enc_lui(v[31:12], k[4:0]));
         run_instr(enc_i(v[11:0], k[4:0], 3'b000, k[4:0], nanorv32_pkg::opc_op_imm));
      end

      // Immediate arithmetic, op 8 is srai
      for (int n = 0; n < 8; n++) begin
         v = $urandom;
         run_instr(enc_lui(v[31:12], 5'($urandom_range(31, 1))));
      end
      for (int op = 0; op < 9; op++) begin
         f3 = (op == 8) ? 3'd5 : op[2:0];
         for (int n = 0; n < n_rand; n++) begin
            imm = 12'($urandom);
            if (f3 == 3'd1 || f3 == 3'd5) begin
               imm = {(op == 8) ? 7'h20 : 7'h00, 5'($urandom_range(31, 0))};
            end
            rd = 5'($urandom_range(31, 1));
            run_instr(enc_i(imm, 5'($urandom_range(31, 0)), f3, rd,
                            nanorv32_pkg::opc_op_imm));
         end
      end

      // Register arithmetic, ops 8 and 9 are sub and sra
      for (int op = 0; op < 10; op++) begin
         f3 = (op < 8) ? op[2:0] : ((op == 8) ? 3'd0 : 3'd5);
         f7 = (op < 8) ? 7'h00 : 7'h20;
         for (int n = 0; n < n_rand; n++) begin
            rd = 5'($urandom_range(31, 1));
            run_instr(enc_r(f7, 5'($urandom_range(31, 0)), 5'($urandom_range(31, 0)),
                            f3, rd, nanorv32_pkg::opc_op));
            // Read back the destination
            run_instr(enc_r(7'h00, 5'd0, rd, 3'b000, 5'd0, nanorv32_pkg::opc_op));
         end
      end

      // Branches on x1 and x2 for every operand pair
      for (int p = 0; p < 6; p++) begin
         pair = branch_pairs[p * 24 +: 24];
         run_instr(enc_i(pair[23:12], 5'd0, 3'b000, 5'd1, nanorv32_pkg::opc_op_imm));
         run_instr(enc_i(pair[11:0], 5'd0, 3'b000, 5'd2, nanorv32_pkg::opc_op_imm));
         for (int c = 0; c < 6; c++) begin
            f3 = (c < 2) ? c[2:0] : 3'(c + 2);
            // A stray write-back would land in x9
            run_instr(enc_r(7'h00, 5'd2, 5'd1, f3, 5'd9, nanorv32_pkg::opc_branch));
         end
      end
      check_all_regs();

      // Writes to x0 report a value but x0 stays zero
      run_instr(enc_i(12'h07b, 5'd3, 3'b000, 5'd0, nanorv32_pkg::opc_op_imm));
      run_instr(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd0, nanorv32_pkg::opc_op));
      run_instr(enc_r(7'h00, 5'd5, 5'd4, 3'b000, 5'd0, nanorv32_pkg::opc_op));
      run_instr(enc_r(7'h00, 5'd0, 5'd0, 3'b110, 5'd0, nanorv32_pkg::opc_op));
      run_instr(enc_lui(20'habcde, 5'd0));
      run_instr(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd0, nanorv32_pkg::opc_op));

      // Illegal words, then confirm no register moved
      run_instr(enc_i(12'h123, 5'd1, 3'b010, 5'd7, 7'b0000011));
      run_instr(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd7, nanorv32_pkg::opc_op));
      run_instr(enc_r(7'h20, 5'd2, 5'd1, 3'b100, 5'd7, nanorv32_pkg::opc_op));
      run_instr(enc_i({7'h20, 5'd3}, 5'd1, 3'b001, 5'd7, nanorv32_pkg::opc_op_imm));
      run_instr(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd7, nanorv32_pkg::opc_branch));
      check_all_regs();

      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
nanorv32_pkg.sv
nanorv32_alu.sv
nanorv32_decode.sv
nanorv32_regfile.sv
nanorv32_exec_ctrl.sv
nanorv32_exec_top.sv
tb_clkgen.sv
nanorv32_exec_tb.sv
